// File: sources.f
+incdir+include
source/rsa_pkg.sv
source/mont_mult.sv
source/mont_domain_entry.sv
source/mod_exp_core.sv
source/rsa_job_port.sv
source/rsa_top.sv
testbench/rsa_asserts.sv
testbench/rsa_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RSA testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module rsa_tb -o Vrsa_tb

# the simulator status is not trusted alone, the log decides
./obj_dir/Vrsa_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
elif grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    echo "simulation ended without a verdict"
    exit 1
fi

// File: testbench/rsa_tb.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module rsa_tb
    import rsa_pkg::*;
();

    localparam int handshake_limit = 64;
    localparam int result_limit    = `RSA_WIDTH * (`RSA_WIDTH + 16) + 256;
    localparam int random_jobs     = 6;

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic        i_job_req;
    rsa_job_t    i_job;
    logic        o_job_ack;
    logic        o_res_req;
    rsa_result_t o_result;
    logic        i_res_ack;
    integer      seed = 47721;
    int          results_seen = 0;

    rsa_top rsa_top_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_job_req (i_job_req),
        .i_job     (i_job),
        .o_job_ack (o_job_ack),
        .o_res_req (o_res_req),
        .o_result  (o_result),
        .i_res_ack (i_res_ack)
    );

    always #10 i_clk = ~i_clk;

    // one result offered per rise of o_res_req
    always @(posedge o_res_req) begin
        results_seen++;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_result(input string name, input rsa_result_t got,
                                input rsa_result_t expected);
        if (got !== expected) begin
            $display("error: time %0t signal %s expected %h got %h",
                     $time, name, expected.value, got.value);
            fail_now("result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("error: time %0t signal %s expected %b got %b",
                     $time, name, expected, got);
            fail_now("handshake flag mismatch");
        end
    endtask

    function automatic logic [`RSA_WIDTH-1:0] rand_word();
        logic [`RSA_WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < `RSA_WIDTH; i += 32) begin
            w = (w << 32) | `RSA_WIDTH'($unsigned($random(seed)));
        end
        return w;
    endfunction

    // odd modulus with top bit set, base already reduced
    function automatic rsa_job_t random_job();
        rsa_job_t j;
        j.modulus                = rand_word();
        j.modulus[0]             = 1'b1;
        j.modulus[`RSA_WIDTH-1]  = 1'b1;
        j.base                   = rand_word() % j.modulus;
        j.exponent               = rand_word();
        return j;
    endfunction

    // plain square-and-multiply, products fit in twice the width
    function automatic rsa_result_t model_pow(input rsa_job_t job);
        logic [2*`RSA_WIDTH-1:0] modulus;
        logic [2*`RSA_WIDTH-1:0] power;
        logic [2*`RSA_WIDTH-1:0] result;
        rsa_result_t             r;
        modulus = {{`RSA_WIDTH{1'b0}}, job.modulus};
        power   = {{`RSA_WIDTH{1'b0}}, job.base} % modulus;
        result  = (2*`RSA_WIDTH)'(1);
        for (int i = 0; i < `RSA_WIDTH; i++) begin
            if (job.exponent[i]) begin
                result = (result * power) % modulus;
            end
            power = (power * power) % modulus;
        end
        r.value = result[`RSA_WIDTH-1:0];
        return r;
    endfunction

    task automatic wait_job_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (o_job_ack !== level) begin
            if (cycles == handshake_limit) begin
                fail_now("timeout: o_job_ack did not reach the expected level");
            end
            cycles++;
            @(negedge i_clk);
        end
    endtask

    task automatic wait_res_req(input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge i_clk);
        while (o_res_req !== level) begin
            if (cycles == limit) begin
                fail_now("timeout: o_res_req did not reach the expected level");
            end
            cycles++;
            @(negedge i_clk);
        end
    endtask

    // second half of the job handshake, request already up
    task automatic finish_intake();
        wait_job_ack(1'b1);
        @(posedge i_clk);
        i_job_req <= 1'b0;
        wait_job_ack(1'b0);
    endtask

    task automatic submit_job(input rsa_job_t job);
        @(posedge i_clk);
        i_job     <= job;
        i_job_req <= 1'b1;
        finish_intake();
    endtask

    // overlap raises the next request before this result is acked
    task automatic collect_result(input rsa_result_t expected, input logic overlap,
                                  input rsa_job_t next_job);
        int delay;
        wait_res_req(1'b1, result_limit);
        check_result("o_result", o_result, expected);
        if (overlap) begin
            @(posedge i_clk);
            i_job     <= next_job;
            i_job_req <= 1'b1;
        end
        delay = int'($unsigned($random(seed)) % 8);
        repeat (delay + 1) begin
            @(negedge i_clk);
            check_result("o_result", o_result, expected); // held under back-pressure
            check_flag("o_res_req", o_res_req, 1'b1);
            check_flag("o_job_ack", o_job_ack, 1'b0);
        end
        @(posedge i_clk);
        i_res_ack <= 1'b1;
        wait_res_req(1'b0, handshake_limit);
        check_flag("o_job_ack", o_job_ack, 1'b0);
        @(posedge i_clk);
        i_res_ack <= 1'b0;
        if (overlap) begin
            finish_intake();
        end
    endtask

    initial begin
        rsa_job_t jobs[$];
        rsa_job_t job;
        rsa_job_t next_job;
        logic     overlap;
        int       n;
        i_rst     = 1'b1;
        i_job_req = 1'b0;
        i_job     = '0;
        i_res_ack = 1'b0;
        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;

        job          = random_job();
        job.exponent = '0;                  // yields one
        jobs.push_back(job);
        job          = random_job();
        job.exponent = `RSA_WIDTH'(1);      // yields the base
        jobs.push_back(job);
        job          = random_job();
        job.exponent = '1;                  // both multipliers on every bit
        job.base     = job.modulus - 1'b1;
        jobs.push_back(job);
        for (int i = 0; i < random_jobs; i++) begin
            jobs.push_back(random_job());
        end
        n = jobs.size();

        submit_job(jobs[0]);
        for (int k = 0; k < n; k++) begin
            overlap  = (k + 1 < n) && (k % 2 == 0);
            next_job = (k + 1 < n) ? jobs[k+1] : jobs[k];
            collect_result(model_pow(jobs[k]), overlap, next_job);
            if (!overlap && k + 1 < n) begin
                submit_job(jobs[k+1]);
            end
        end

        // quiet window catches a late repeated offer
        repeat (handshake_limit) @(negedge i_clk);

        if (results_seen == n) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("got %0d results for %0d jobs", results_seen, n);
            $display("CHECKS FAILED");
            $fatal(1, "result count wrong");
        end
    end

endmodule

// File: testbench/rsa_asserts.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module rsa_asserts
    import rsa_pkg::*;
(
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_job_req,
    input rsa_job_t    i_job,
    input logic        o_job_ack,
    input logic        o_res_req,
    input rsa_result_t o_result,
    input logic        i_res_ack,
    input logic        o_start
);

    logic job_open_r; // from core start until the result ack is seen

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            job_open_r <= 1'b0;
        end else if (o_start) begin
            job_open_r <= 1'b1;
        end else if (!o_res_req && i_res_ack) begin
            job_open_r <= 1'b0;
        end
    end

    a_job_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_job_req && $past(i_job_req)) |-> $stable(i_job))
        else $error("i_job changed while i_job_req was high");

    a_result_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_res_req && $past(o_res_req)) |-> $stable(o_result))
        else $error("o_result changed while o_res_req was high");

    a_ack_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_job_ack) |-> !$past(job_open_r))
        else $error("o_job_ack rose while a job was still open");

    a_res_release: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(o_res_req) |-> $past(i_res_ack))
        else $error("o_res_req fell without i_res_ack");

endmodule

bind rsa_job_port rsa_asserts u_asserts (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_job_req (i_job_req),
    .i_job     (i_job),
    .o_job_ack (o_job_ack),
    .o_res_req (o_res_req),
    .o_result  (o_result),
    .i_res_ack (i_res_ack),
    .o_start   (o_start)
);

// File: source/rsa_top.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module rsa_top
    import rsa_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_job_req,
    input  rsa_job_t    i_job,
    output logic        o_job_ack,
    output logic        o_res_req,
    output rsa_result_t o_result,
    input  logic        i_res_ack
);

    logic                  core_start;
    rsa_job_t              core_job;   // held operands
    logic                  core_done;
    logic [`RSA_WIDTH-1:0] core_value;

    rsa_job_port u_port (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_job_req (i_job_req),
        .i_job     (i_job),
        .o_job_ack (o_job_ack),
        .o_res_req (o_res_req),
        .o_result  (o_result),
        .i_res_ack (i_res_ack),
        .o_start   (core_start),
        .o_job     (core_job),
        .i_done    (core_done),
        .i_value   (core_value)
    );

    mod_exp_core u_core (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (core_start),
        .i_job   (core_job),
        .o_done  (core_done),
        .o_value (core_value)
    );

endmodule

// File: source/rsa_job_port.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module rsa_job_port
    import rsa_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_job_req,
    input  rsa_job_t              i_job,
    output logic                  o_job_ack,
    output logic                  o_res_req,
    output rsa_result_t           o_result,
    input  logic                  i_res_ack,
    output logic                  o_start,
    output rsa_job_t              o_job,
    input  logic                  i_done,
    input  logic [`RSA_WIDTH-1:0] i_value
);

    typedef enum logic [2:0] {
        ph_idle,
        ph_acked,   // waiting for the job request to drop
        ph_busy,    // core running
        ph_present, // result offered
        ph_release  // waiting for the result ack to drop
    } port_phase_t;

    port_phase_t phase_r;
    logic        ack_r;
    logic        req_r;
    logic        start_r;
    logic        done_seen_r;  // core may finish before the requester lets go
    rsa_job_t    job_r;
    rsa_result_t result_r;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            phase_r     <= ph_idle;
            ack_r       <= 1'b0;
            req_r       <= 1'b0;
            start_r     <= 1'b0;
            done_seen_r <= 1'b0;
            result_r    <= '0;
        end else begin
            start_r <= 1'b0;
            case (phase_r)
                ph_idle: begin
                    if (i_job_req) begin
                        ack_r   <= 1'b1;
                        start_r <= 1'b1;
                        phase_r <= ph_acked;
                    end
                end
                ph_acked: begin
                    if (!i_job_req) begin
                        ack_r   <= 1'b0;
                        phase_r <= ph_busy;
                    end
                end
                ph_busy: begin
                    if (done_seen_r) begin
                        req_r       <= 1'b1;
                        done_seen_r <= 1'b0;
                        phase_r     <= ph_present;
                    end
                end
                ph_present: begin
                    if (i_res_ack) begin
                        req_r   <= 1'b0;
                        phase_r <= ph_release;
                    end
                end
                ph_release: begin
                    if (!i_res_ack) begin
                        phase_r <= ph_idle; // only now a new job is taken
                    end
                end
                default: phase_r <= ph_idle;
            endcase
            // one job in flight, so this never lands while presenting
            if (i_done) begin
                result_r.value <= i_value;
                done_seen_r    <= 1'b1;
            end
        end
    end

    // job held steady for the core until the next intake
    always_ff @(posedge i_clk) begin
        if (phase_r == ph_idle && i_job_req) begin
            job_r <= i_job;
        end
    end

    assign o_job_ack = ack_r;
    assign o_res_req = req_r;
    assign o_result  = result_r;
    assign o_start   = start_r;
    assign o_job     = job_r;

endmodule

// File: source/mod_exp_core.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module mod_exp_core
    import rsa_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  rsa_job_t              i_job,
    output logic                  o_done,
    output logic [`RSA_WIDTH-1:0] o_value
);

    localparam logic [`RSA_CNT_W-1:0] bit_total = `RSA_CNT_W'(`RSA_WIDTH);

    exp_state_t            state_r;
    logic [`RSA_CNT_W-1:0] bit_cnt_r;
    logic [`RSA_WIDTH-1:0] exp_sh_r;      // exponent, current bit at 0
    logic [`RSA_WIDTH-1:0] power_r;       // base^(2^i), montgomery domain
    logic [`RSA_WIDTH-1:0] acc_r;         // plain domain, starts at one
    logic                  entry_start_r;
    logic                  sq_start_r;
    logic                  mul_start_r;
    logic                  sq_pend_r;
    logic                  mul_pend_r;
    logic                  done_r;
    logic                  entry_fin;
    logic                  sq_fin;
    logic                  mul_fin;
    logic [`RSA_WIDTH-1:0] entry_res;
    logic [`RSA_WIDTH-1:0] sq_res;
    logic [`RSA_WIDTH-1:0] mul_res;
    logic                  advance;

    mont_domain_entry u_entry (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (entry_start_r),
        .i_value    (i_job.base),
        .i_modulus  (i_job.modulus),
        .o_finished (entry_fin),
        .o_result   (entry_res)
    );

    // squarer, power stays in montgomery domain
    mont_mult u_square (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (sq_start_r),
        .i_a        (power_r),
        .i_b        (power_r),
        .i_modulus  (i_job.modulus),
        .o_finished (sq_fin),
        .o_result   (sq_res)
    );

    // acc * power * R^-1 cancels the montgomery factor of power
    mont_mult u_accum (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (mul_start_r),
        .i_a        (acc_r),
        .i_b        (power_r),
        .i_modulus  (i_job.modulus),
        .o_finished (mul_fin),
        .o_result   (mul_res)
    );

    // every unit started for this bit has reported back
    assign advance = !(sq_pend_r && !sq_fin) && !(mul_pend_r && !mul_fin);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r       <= exp_idle;
            bit_cnt_r     <= '0;
            entry_start_r <= 1'b0;
            sq_start_r    <= 1'b0;
            mul_start_r   <= 1'b0;
            sq_pend_r     <= 1'b0;
            mul_pend_r    <= 1'b0;
            done_r        <= 1'b0;
        end else begin
            entry_start_r <= 1'b0; // all pulses last one cycle
            sq_start_r    <= 1'b0;
            mul_start_r   <= 1'b0;
            done_r        <= 1'b0;
            case (state_r)
                exp_idle: begin
                    if (i_start) begin
                        entry_start_r <= 1'b1;
                        bit_cnt_r     <= '0;
                        state_r       <= exp_enter;
                    end
                end
                exp_enter: begin
                    if (entry_fin) begin
                        state_r <= exp_step;
                    end
                end
                exp_step: begin
                    if (bit_cnt_r == bit_total) begin
                        done_r  <= 1'b1;
                        state_r <= exp_idle;
                    end else begin
                        sq_start_r  <= 1'b1;
                        sq_pend_r   <= 1'b1;
                        mul_start_r <= exp_sh_r[0]; // only for a set bit
                        mul_pend_r  <= exp_sh_r[0];
                        state_r     <= exp_mult;
                    end
                end
                exp_mult: begin
                    if (sq_fin) begin
                        sq_pend_r <= 1'b0;
                    end
                    if (mul_fin) begin
                        mul_pend_r <= 1'b0;
                    end
                    if (advance) begin
                        bit_cnt_r <= bit_cnt_r + 1'b1;
                        state_r   <= exp_step;
                    end
                end
                default: state_r <= exp_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == exp_idle && i_start) begin
            acc_r    <= `RSA_WIDTH'(1);
            exp_sh_r <= i_job.exponent;
        end
        if (state_r == exp_enter && entry_fin) begin
            power_r <= entry_res;
        end
        if (state_r == exp_mult) begin
            if (sq_fin) begin
                power_r <= sq_res;
            end
            if (mul_fin) begin
                acc_r <= mul_res;
            end
            if (advance) begin
                exp_sh_r <= exp_sh_r >> 1;
            end
        end
    end

    assign o_done  = done_r;
    assign o_value = acc_r;

endmodule

// File: source/mont_domain_entry.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module mont_domain_entry (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [`RSA_WIDTH-1:0] i_value,
    input  logic [`RSA_WIDTH-1:0] i_modulus,
    output logic                  o_finished,
    output logic [`RSA_WIDTH-1:0] o_result
);

    localparam logic [`RSA_CNT_W-1:0] last_cnt = `RSA_CNT_W'(`RSA_WIDTH - 1);

    logic                  busy_r;
    logic [`RSA_CNT_W-1:0] cnt_r;      // doublings done so far
    logic                  finished_r;
    logic [`RSA_WIDTH-1:0] val_r;
    logic [`RSA_WIDTH:0]   dbl;        // one bit of carry headroom
    logic [`RSA_WIDTH:0]   dbl_red;

    // value is below the modulus, so one subtraction is enough
    assign dbl     = {val_r, 1'b0};
    assign dbl_red = (dbl >= {1'b0, i_modulus}) ? dbl - {1'b0, i_modulus} : dbl;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy_r     <= 1'b0;
            cnt_r      <= '0;
            finished_r <= 1'b0;
        end else begin
            finished_r <= 1'b0;
            if (!busy_r) begin
                if (i_start) begin
                    busy_r <= 1'b1;
                    cnt_r  <= '0;
                end
            end else begin
                cnt_r <= cnt_r + 1'b1;
                if (cnt_r == last_cnt) begin
                    busy_r     <= 1'b0;
                    finished_r <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy_r && i_start) begin
            val_r <= i_value;
        end else if (busy_r) begin
            val_r <= dbl_red[`RSA_WIDTH-1:0]; // top bit is zero after reduction
        end
    end

    assign o_finished = finished_r;
    assign o_result   = val_r;

endmodule

// File: source/mont_mult.sv
`timescale 1ns/1ps
`include "rsa_settings.svh"

module mont_mult (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic [`RSA_WIDTH-1:0] i_a,
    input  logic [`RSA_WIDTH-1:0] i_b,
    input  logic [`RSA_WIDTH-1:0] i_modulus,
    output logic                  o_finished,
    output logic [`RSA_WIDTH-1:0] o_result
);

    localparam logic [`RSA_CNT_W-1:0] fix_cnt = `RSA_CNT_W'(`RSA_WIDTH);

    logic                  busy_r;
    logic [`RSA_CNT_W-1:0] cnt_r;      // index of the next a bit
    logic                  finished_r;
    logic [`RSA_WIDTH-1:0] a_sh_r;     // remaining bits of a, next one at 0
    logic [`RSA_WIDTH:0]   acc_r;      // stays below twice the modulus
    logic                  load;
    logic                  fix_now;
    logic [`RSA_WIDTH:0]   acc_cur;
    logic                  a_bit;
    logic [`RSA_WIDTH+1:0] sum_b;
    logic [`RSA_WIDTH+1:0] sum_n;
    logic [`RSA_WIDTH:0]   acc_next;
    logic [`RSA_WIDTH:0]   acc_fix;

    // bit 0 is handled in the start cycle itself
    assign load    = i_start && !busy_r;
    assign fix_now = (cnt_r == fix_cnt);
    assign acc_cur = load ? '0 : acc_r;
    assign a_bit   = load ? i_a[0] : a_sh_r[0];

    assign sum_b    = {1'b0, acc_cur} + (a_bit ? {2'b00, i_b} : '0);
    assign sum_n    = sum_b + (sum_b[0] ? {2'b00, i_modulus} : '0); // make it even
    assign acc_next = sum_n[`RSA_WIDTH+1:1];
    assign acc_fix  = (acc_r >= {1'b0, i_modulus}) ? acc_r - {1'b0, i_modulus} : acc_r;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy_r     <= 1'b0;
            cnt_r      <= '0;
            finished_r <= 1'b0;
        end else begin
            finished_r <= 1'b0;
            if (load) begin
                busy_r <= 1'b1;
                cnt_r  <= `RSA_CNT_W'(1);
            end else if (busy_r) begin
                if (fix_now) begin
                    busy_r     <= 1'b0;
                    finished_r <= 1'b1;
                end else begin
                    cnt_r <= cnt_r + 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge i_clk) begin
        if (load) begin
            acc_r  <= acc_next;
            a_sh_r <= i_a >> 1;
        end else if (busy_r) begin
            a_sh_r <= a_sh_r >> 1;
            if (fix_now) begin
                acc_r <= acc_fix; // final conditional subtraction
            end else begin
                acc_r <= acc_next;
            end
        end
    end

    assign o_finished = finished_r;
    assign o_result   = acc_r[`RSA_WIDTH-1:0];

endmodule

// File: source/rsa_pkg.sv
`include "rsa_settings.svh"

package rsa_pkg;

    // one decryption request, held by the job port while the core runs
    typedef struct packed {
        logic [`RSA_WIDTH-1:0] base;     // cipher text, below modulus
        logic [`RSA_WIDTH-1:0] exponent; // private key
        logic [`RSA_WIDTH-1:0] modulus;  // must be odd
    } rsa_job_t;

    typedef struct packed {
        logic [`RSA_WIDTH-1:0] value; // plain text
    } rsa_result_t;

    // exponentiation sequencer
    typedef enum logic [1:0] {
        exp_idle,
        exp_enter, // base into montgomery domain
        exp_step,  // pick up next exponent bit
        exp_mult   // squarer and maybe accumulator running
    } exp_state_t;

endpackage

// File: include/rsa_settings.svh
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// operand width in bits, 8 or more
`define RSA_WIDTH 256

// iteration counters, wide enough to hold RSA_WIDTH itself
`define RSA_CNT_W ($clog2(`RSA_WIDTH) + 1)

`endif
